// File: source/pix_cfg.svh
`ifndef PIX_CFG_SVH
`define PIX_CFG_SVH

`default_nettype none

// ========================================
// Image and memory geometry
// ========================================

// Words in one image, which is also the size of one memory block
`define PIX_IMAGE_SIZE      64
`define PIX_BLOCK_COUNT     4

// Four blocks of 64 words
`define PIX_ADDR_WIDTH      8

// ========================================
// Queue depths
// ========================================
`define PIX_IN_FIFO_DEPTH   16
`define PIX_OUT_FIFO_DEPTH  8

`default_nettype wire

`endif

// File: source/pix_pkg.sv
`include "pix_cfg.svh"

`default_nettype none

package pix_pkg;

    // ========================================
    // Command encoding
    // ========================================
    typedef enum logic [1:0] {
        PIX_CMD_NONE    = 2'b00,
        PIX_CMD_CAPTURE = 2'b01,
        PIX_CMD_READOUT = 2'b10
    } pix_cmd_t;

    // ========================================
    // Data and address types
    // ========================================

    // Raw sensor sample
    typedef logic [11:0] pix_sample_t;

    // Memory word, samples are stored zero-extended
    typedef logic [15:0] ram_word_t;

    typedef logic [$clog2(`PIX_BLOCK_COUNT)-1:0] ram_block_t;

    // Word address across all blocks
    typedef logic [`PIX_ADDR_WIDTH-1:0] ram_addr_t;

endpackage

`default_nettype wire

// File: source/pix_fifo.sv
`timescale 1ns/1ps

`default_nettype none

module pix_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 8
) (
    input  logic     clk,
    input  logic     fifoIn_rst,
    input  logic     flush,
    input  logic     push,
    input  payload_t push_data,
    output logic     full,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push_ok;
    logic             pop_ok;

    // Pointer advance with wrap, DEPTH need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign push_ok  = push && !full;
    assign pop_ok   = pop && !empty;

    // First word falls through
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_ok)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk) begin
        if (!fifoIn_rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop_ok)
                rd_ptr <= next_ptr(rd_ptr);
            // Simultaneous push and pop leaves the count alone
            if (push_ok && !pop_ok)
                count <= count + 1'b1;
            else if (pop_ok && !push_ok)
                count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/pix_input.sv
`timescale 1ns/1ps

`default_nettype none

module pix_input (
    input  logic                 clk,
    input  logic                 fifoIn_rst,
    input  logic                 start,
    input  pix_pkg::pix_sample_t pix_d,
    input  logic                 pix_fv,
    input  logic                 pix_lv,
    output logic                 fifo_flush,
    output logic                 fifo_push,
    output pix_pkg::pix_sample_t fifo_data,
    input  logic                 fifo_full,
    output logic                 frame_end,
    output logic                 pixel_dropped
);

    import pix_pkg::*;

    typedef enum logic [1:0] {
        IN_IDLE,
        IN_WAIT_LOW,
        IN_WAIT_HIGH,
        IN_ACTIVE
    } in_state_t;

    in_state_t   state;
    pix_sample_t pix_d_reg;
    logic        pix_fv_reg;
    logic        pix_lv_reg;

    // ========================================
    // Pin registers
    // ========================================
    always_ff @(posedge clk) begin
        pix_d_reg <= pix_d;
    end

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            pix_fv_reg <= 1'b0;
            pix_lv_reg <= 1'b0;
        end else begin
            pix_fv_reg <= pix_fv;
            pix_lv_reg <= pix_lv;
        end
    end

    // ========================================
    // Frame sync
    // ========================================

    // Queue is emptied in the same cycle the capture is armed
    assign fifo_flush = start;

    // The first sample of a frame may come with the rising frame strobe
    assign fifo_push = ((state == IN_WAIT_HIGH) || (state == IN_ACTIVE)) &&
                       pix_fv_reg && pix_lv_reg;
    assign fifo_data = pix_d_reg;

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state         <= IN_IDLE;
            frame_end     <= 1'b0;
            pixel_dropped <= 1'b0;
        end else begin
            frame_end <= 1'b0;
            case (state)
                IN_IDLE: ;
                // Skip any frame already in progress
                IN_WAIT_LOW: begin
                    if (!pix_fv_reg)
                        state <= IN_WAIT_HIGH;
                end
                IN_WAIT_HIGH: begin
                    if (pix_fv_reg)
                        state <= IN_ACTIVE;
                end
                IN_ACTIVE: begin
                    if (!pix_fv_reg) begin
                        frame_end <= 1'b1;
                        state     <= IN_IDLE;
                    end
                end
                default: state <= IN_IDLE;
            endcase

            // Sticky until the next capture
            if (fifo_push && fifo_full)
                pixel_dropped <= 1'b1;

            if (start) begin
                state         <= IN_WAIT_LOW;
                pixel_dropped <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/ram_controller.sv
`timescale 1ns/1ps

`include "pix_cfg.svh"

`default_nettype none

module ram_controller (
    input  logic                 clk,
    input  logic                 fifoIn_rst,
    input  logic                 write_start,
    input  logic                 read_start,
    input  pix_pkg::ram_block_t  block,
    input  pix_pkg::pix_sample_t in_data,
    input  logic                 in_empty,
    output logic                 in_pop,
    output pix_pkg::ram_word_t   out_data,
    input  logic                 out_full,
    output logic                 out_push,
    output logic                 done,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    output pix_pkg::ram_addr_t   wb_adr,
    output pix_pkg::ram_word_t   wb_wdata,
    input  pix_pkg::ram_word_t   wb_rdata,
    input  logic                 wb_ack
);

    import pix_pkg::*;

    localparam int CNT_W = $clog2(`PIX_IMAGE_SIZE + 1);

    typedef enum logic [1:0] {
        RC_IDLE,
        RC_WRITE,
        RC_READ,
        RC_ACK
    } rc_state_t;

    rc_state_t        state;
    ram_addr_t        base;
    logic [CNT_W-1:0] word_cnt;
    logic             any_start;
    logic             issue_write;
    logic             issue_read;

    assign any_start = write_start || read_start;

    // ========================================
    // Transfer issue
    // ========================================

    // A new start overrides whatever mode was waiting
    assign issue_write = (state == RC_WRITE) && !in_empty && !any_start;
    assign issue_read  = (state == RC_READ) && !out_full && !any_start;
    assign in_pop      = issue_write;

    // Read data goes to the output queue in the ack cycle
    assign out_push = (state == RC_ACK) && !wb_we && wb_ack;
    assign out_data = wb_rdata;

    always_ff @(posedge clk) begin
        if (any_start)
            base <= ram_addr_t'(block) << $clog2(`PIX_IMAGE_SIZE);
        if (issue_write || issue_read)
            wb_adr <= base + ram_addr_t'(word_cnt);
        // Zero-extend the sample
        if (issue_write)
            wb_wdata <= ram_word_t'(in_data);
    end

    // ========================================
    // Bus state machine
    // ========================================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state    <= RC_IDLE;
            word_cnt <= '0;
            wb_cyc   <= 1'b0;
            wb_stb   <= 1'b0;
            wb_we    <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (any_start) begin
                state    <= write_start ? RC_WRITE : RC_READ;
                word_cnt <= '0;
                wb_we    <= write_start;
            end else begin
                case (state)
                    RC_IDLE: ;
                    RC_WRITE, RC_READ: begin
                        if (issue_write || issue_read) begin
                            wb_cyc <= 1'b1;
                            wb_stb <= 1'b1;
                            state  <= RC_ACK;
                        end
                    end
                    RC_ACK: begin
                        // Cycle drops for at least one clock before the next one
                        if (wb_ack) begin
                            wb_cyc   <= 1'b0;
                            wb_stb   <= 1'b0;
                            word_cnt <= word_cnt + 1'b1;
                            if (word_cnt == CNT_W'(`PIX_IMAGE_SIZE - 1)) begin
                                done  <= 1'b1;
                                state <= RC_IDLE;
                            end else begin
                                state <= wb_we ? RC_WRITE : RC_READ;
                            end
                        end
                    end
                    default: state <= RC_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: source/pix_controller.sv
`timescale 1ns/1ps

`include "pix_cfg.svh"

`default_nettype none

module pix_controller (
    input  logic                 clk,
    input  logic                 fifoIn_rst,
    input  pix_pkg::pix_cmd_t    cmd,
    input  pix_pkg::ram_block_t  cmd_block,
    input  pix_pkg::pix_sample_t pix_d,
    input  logic                 pix_fv,
    input  logic                 pix_lv,
    output logic                 readout_ready,
    input  logic                 readout_trigger,
    output pix_pkg::ram_word_t   readout_data,
    output logic                 status_capture_done,
    output logic                 status_capture_pixel_dropped,
    output logic                 status_readout_started,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    output pix_pkg::ram_addr_t   wb_adr,
    output pix_pkg::ram_word_t   wb_wdata,
    input  pix_pkg::ram_word_t   wb_rdata,
    input  logic                 wb_ack
);

    import pix_pkg::*;

    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_CAP_START,
        CTRL_CAP_RUN,
        CTRL_RD_START,
        CTRL_RD_RUN
    } ctrl_state_t;

    ctrl_state_t ctrl_state;
    ram_block_t  block_q;
    logic        frame_end_seen;
    logic        capture_start;
    logic        read_start;

    // Input queue
    logic        in_flush;
    logic        in_push;
    pix_sample_t in_push_data;
    logic        in_full;
    logic        in_pop;
    pix_sample_t in_pop_data;
    logic        in_empty;
    logic        frame_end;

    // Output queue
    logic        out_push;
    ram_word_t   out_push_data;
    logic        out_full;
    logic        out_empty;
    logic        ram_done;

    assign capture_start = (ctrl_state == CTRL_CAP_START);
    assign read_start    = (ctrl_state == CTRL_RD_START);

    // ========================================
    // Pixel input and input queue
    // ========================================
    pix_input pix_input_i (
        .clk           (clk),
        .fifoIn_rst    (fifoIn_rst),
        .start         (capture_start),
        .pix_d         (pix_d),
        .pix_fv        (pix_fv),
        .pix_lv        (pix_lv),
        .fifo_flush    (in_flush),
        .fifo_push     (in_push),
        .fifo_data     (in_push_data),
        .fifo_full     (in_full),
        .frame_end     (frame_end),
        .pixel_dropped (status_capture_pixel_dropped)
    );

    pix_fifo #(
        .payload_t (pix_sample_t),
        .DEPTH     (`PIX_IN_FIFO_DEPTH)
    ) fifo_in_i (
        .clk        (clk),
        .fifoIn_rst (fifoIn_rst),
        .flush      (in_flush),
        .push       (in_push),
        .push_data  (in_push_data),
        .full       (in_full),
        .pop        (in_pop),
        .pop_data   (in_pop_data),
        .empty      (in_empty)
    );

    // ========================================
    // Memory engine
    // ========================================
    ram_controller ram_controller_i (
        .clk         (clk),
        .fifoIn_rst  (fifoIn_rst),
        .write_start (capture_start),
        .read_start  (read_start),
        .block       (block_q),
        .in_data     (in_pop_data),
        .in_empty    (in_empty),
        .in_pop      (in_pop),
        .out_data    (out_push_data),
        .out_full    (out_full),
        .out_push    (out_push),
        .done        (ram_done),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_wdata    (wb_wdata),
        .wb_rdata    (wb_rdata),
        .wb_ack      (wb_ack)
    );

    // ========================================
    // Output queue to readout port
    // ========================================
    pix_fifo #(
        .payload_t (ram_word_t),
        .DEPTH     (`PIX_OUT_FIFO_DEPTH)
    ) fifo_out_i (
        .clk        (clk),
        .fifoIn_rst (fifoIn_rst),
        .flush      (read_start),
        .push       (out_push),
        .push_data  (out_push_data),
        .full       (out_full),
        .pop        (readout_trigger),
        .pop_data   (readout_data),
        .empty      (out_empty)
    );

    assign readout_ready = !out_empty;

    // ========================================
    // Command FSM
    // ========================================
    always_ff @(posedge clk) begin
        if ((ctrl_state == CTRL_IDLE) && (cmd != PIX_CMD_NONE))
            block_q <= cmd_block;
    end

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            ctrl_state             <= CTRL_IDLE;
            frame_end_seen         <= 1'b0;
            status_capture_done    <= 1'b0;
            status_readout_started <= 1'b0;
        end else begin
            status_capture_done    <= 1'b0;
            status_readout_started <= 1'b0;
            case (ctrl_state)
                CTRL_IDLE: begin
                    if (cmd == PIX_CMD_CAPTURE)
                        ctrl_state <= CTRL_CAP_START;
                    else if (cmd == PIX_CMD_READOUT)
                        ctrl_state <= CTRL_RD_START;
                end
                CTRL_CAP_START: begin
                    frame_end_seen <= 1'b0;
                    ctrl_state     <= CTRL_CAP_RUN;
                end
                CTRL_CAP_RUN: begin
                    if (frame_end)
                        frame_end_seen <= 1'b1;
                    // Full block written, or a short frame fully drained
                    if (ram_done || (frame_end_seen && in_empty && !wb_cyc)) begin
                        status_capture_done <= 1'b1;
                        ctrl_state          <= CTRL_IDLE;
                    end
                end
                CTRL_RD_START: begin
                    status_readout_started <= 1'b1;
                    ctrl_state             <= CTRL_RD_RUN;
                end
                // Stay busy until all reads are issued and acknowledged
                CTRL_RD_RUN: begin
                    if (ram_done)
                        ctrl_state <= CTRL_IDLE;
                end
                default: ctrl_state <= CTRL_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: dv/wb_ram_model.sv
`timescale 1ns/1ps

`include "pix_cfg.svh"

`default_nettype none

module wb_ram_model (
    input  logic               clk,
    input  logic               fifoIn_rst,
    input  logic [3:0]         ack_delay,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  pix_pkg::ram_addr_t wb_adr,
    input  pix_pkg::ram_word_t wb_wdata,
    output pix_pkg::ram_word_t wb_rdata,
    output logic               wb_ack
);

    import pix_pkg::*;

    localparam int WORDS = 1 << `PIX_ADDR_WIDTH;

    ram_word_t  mem [WORDS];
    logic [3:0] wait_cnt;

    // Known fill so that unwritten words stand out
    initial begin
        int addr;
        for (addr = 0; addr < WORDS; addr++)
            mem[addr] = {8'hA5, 8'(addr)};
    end

    // One word per cycle, ack after ack_delay wait states
    always @(posedge clk) begin
        if (!fifoIn_rst) begin
            wb_ack   <= 1'b0;
            wait_cnt <= '0;
        end else begin
            wb_ack <= 1'b0;
            if (wb_cyc && wb_stb && !wb_ack) begin
                if (wait_cnt >= ack_delay) begin
                    wb_ack   <= 1'b1;
                    wait_cnt <= '0;
                    if (wb_we)
                        mem[wb_adr] <= wb_wdata;
                    else
                        wb_rdata <= mem[wb_adr];
                end else begin
                    wait_cnt <= wait_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/pix_assertions.sv
`timescale 1ns/1ps

`default_nettype none

module pix_assertions (
    input logic               clk,
    input logic               fifoIn_rst,
    input logic               wb_cyc,
    input logic               wb_stb,
    input pix_pkg::ram_addr_t wb_adr,
    input logic               wb_ack,
    input logic               status_capture_done,
    input logic               status_readout_started
);

    int assert_errors = 0;

    // ========================================
    // Wishbone classic master
    // ========================================
    stb_inside_cyc: assert property (@(posedge clk) disable iff (!fifoIn_rst)
        wb_stb |-> wb_cyc)
        else begin
            assert_errors++;
            $error("wb_stb high outside a bus cycle");
        end

    // Request held with a steady address until the slave answers
    stb_held_until_ack: assert property (@(posedge clk) disable iff (!fifoIn_rst)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)))
        else begin
            assert_errors++;
            $error("wb_stb dropped or wb_adr moved before wb_ack");
        end

    cyc_low_in_reset: assert property (@(posedge clk)
        !fifoIn_rst |=> !wb_cyc)
        else begin
            assert_errors++;
            $error("wb_cyc high during reset");
        end

    // ========================================
    // Status pulses
    // ========================================
    capture_done_single: assert property (@(posedge clk) disable iff (!fifoIn_rst)
        status_capture_done |=> !status_capture_done)
        else begin
            assert_errors++;
            $error("status_capture_done longer than one cycle");
        end

    readout_started_single: assert property (@(posedge clk) disable iff (!fifoIn_rst)
        status_readout_started |=> !status_readout_started)
        else begin
            assert_errors++;
            $error("status_readout_started longer than one cycle");
        end

endmodule

bind pix_controller pix_assertions pix_assertions_i (
    .clk                    (clk),
    .fifoIn_rst             (fifoIn_rst),
    .wb_cyc                 (wb_cyc),
    .wb_stb                 (wb_stb),
    .wb_adr                 (wb_adr),
    .wb_ack                 (wb_ack),
    .status_capture_done    (status_capture_done),
    .status_readout_started (status_readout_started)
);

`default_nettype wire

// File: dv/pix_tb.sv
`timescale 1ns/1ps

`include "pix_cfg.svh"

`default_nettype none

module pix_tb;

    import pix_pkg::*;

    localparam int IMAGE_SIZE     = `PIX_IMAGE_SIZE;
    localparam int FRAME_CYCLES   = 256;
    localparam int READOUT_CYCLES = 512;
    // Six frames counting the partial one, five readouts
    localparam int FRAME_COUNT    = 6;
    localparam int READOUT_COUNT  = 5;
    localparam int TIMEOUT_CYCLES =
        4 * (FRAME_COUNT * FRAME_CYCLES + READOUT_COUNT * READOUT_CYCLES);

    logic        clk;
    logic        fifoIn_rst;
    pix_cmd_t    cmd;
    ram_block_t  cmd_block;
    pix_sample_t pix_d;
    logic        pix_fv;
    logic        pix_lv;
    logic        readout_ready;
    logic        readout_trigger;
    ram_word_t   readout_data;
    logic        status_capture_done;
    logic        status_capture_pixel_dropped;
    logic        status_readout_started;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    ram_addr_t   wb_adr;
    ram_word_t   wb_wdata;
    ram_word_t   wb_rdata;
    logic        wb_ack;
    logic [3:0]  ack_delay;

    logic [31:0] rng_state = 32'h6d4eff45;
    logic [31:0] cur_seed;
    int          rd_index;
    logic        rd_check;
    logic        capture_done_seen;
    int          cycle_count;
    int          error_count;
    int          check_count;
    int          test_errors;
    int          tests_run;
    int          tests_clean;
    string       test_name;

    pix_controller dut_i (
        .clk                          (clk),
        .fifoIn_rst                   (fifoIn_rst),
        .cmd                          (cmd),
        .cmd_block                    (cmd_block),
        .pix_d                        (pix_d),
        .pix_fv                       (pix_fv),
        .pix_lv                       (pix_lv),
        .readout_ready                (readout_ready),
        .readout_trigger              (readout_trigger),
        .readout_data                 (readout_data),
        .status_capture_done          (status_capture_done),
        .status_capture_pixel_dropped (status_capture_pixel_dropped),
        .status_readout_started       (status_readout_started),
        .wb_cyc                       (wb_cyc),
        .wb_stb                       (wb_stb),
        .wb_we                        (wb_we),
        .wb_adr                       (wb_adr),
        .wb_wdata                     (wb_wdata),
        .wb_rdata                     (wb_rdata),
        .wb_ack                       (wb_ack)
    );

    wb_ram_model ram_model_i (
        .clk        (clk),
        .fifoIn_rst (fifoIn_rst),
        .ack_delay  (ack_delay),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_wdata   (wb_wdata),
        .wb_rdata   (wb_rdata),
        .wb_ack     (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ========================================
    // Reference model and random source
    // ========================================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Sample n of a frame is the low 12 bits of step n+1, stored zero-extended
    function automatic ram_word_t expected_word(input logic [31:0] seed, input int n);
        logic [31:0] x;
        int          i;
        x = seed;
        for (i = 0; i <= n; i++)
            x = xorshift32(x);
        return {4'h0, x[11:0]};
    endfunction

    task automatic next_random(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    // ========================================
    // Checks and reporting
    // ========================================
    task automatic compare_word(input string name, input ram_word_t got, input ram_word_t exp);
        check_count++;
        if (got !== exp) begin
            $display("** Error at %0t: %s = 0x%04h, expected 0x%04h", $time, name, got, exp);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("At %0t: %s", $time, msg);
        error_count++;
        test_errors++;
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
        tests_run++;
    endtask

    task automatic end_test();
        if (test_errors == 0)
            tests_clean++;
        $display("Test %0d, %s: %s (%0d errors)", tests_run, test_name,
                 (test_errors == 0) ? "clean" : "mismatches", test_errors);
    endtask

    // ========================================
    // Stimulus
    // ========================================
    task automatic next_drive_slot();
        @(posedge clk);
        #2;
    endtask

    task automatic issue_capture(input ram_block_t b);
        capture_done_seen = 1'b0;
        next_drive_slot();
        cmd       = PIX_CMD_CAPTURE;
        cmd_block = b;
        next_drive_slot();
        cmd = PIX_CMD_NONE;
    endtask

    // Eight lines of eight samples, gap cycles of line blanking
    task automatic send_frame(input logic [31:0] seed, input int gap);
        logic [31:0] x;
        int          line;
        int          col;
        x      = seed;
        pix_fv = 1'b0;
        pix_lv = 1'b0;
        repeat (4) next_drive_slot();
        pix_fv = 1'b1;
        repeat (2) next_drive_slot();
        for (line = 0; line < 8; line++) begin
            for (col = 0; col < 8; col++) begin
                x      = xorshift32(x);
                pix_d  = x[11:0];
                pix_lv = 1'b1;
                next_drive_slot();
            end
            pix_lv = 1'b0;
            repeat (gap) next_drive_slot();
        end
        pix_fv = 1'b0;
        repeat (4) next_drive_slot();
    endtask

    task automatic wait_capture_done();
        int waited;
        waited = 0;
        while (!capture_done_seen && waited < FRAME_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (!capture_done_seen)
            note_failure("status_capture_done never pulsed after the frame");
    endtask

    task automatic capture_frame(input ram_block_t b, input logic [31:0] seed, input int gap);
        issue_capture(b);
        send_frame(seed, gap);
        wait_capture_done();
    endtask

    task automatic read_block(input ram_block_t b, input logic [31:0] seed,
                              input logic random_trigger);
        logic [31:0] r;
        int          waited;
        cur_seed = seed;
        rd_index = 0;
        rd_check = 1'b1;
        next_drive_slot();
        cmd       = PIX_CMD_READOUT;
        cmd_block = b;
        next_drive_slot();
        cmd = PIX_CMD_NONE;
        // Pulse lands in the second cycle after the command is taken
        @(negedge clk);
        compare_bit("status_readout_started", status_readout_started, 1'b0);
        @(negedge clk);
        compare_bit("status_readout_started", status_readout_started, 1'b1);
        waited = 0;
        while (rd_index < IMAGE_SIZE && waited < READOUT_CYCLES) begin
            next_drive_slot();
            if (random_trigger) begin
                next_random(r);
                readout_trigger = r[0];
            end else begin
                readout_trigger = 1'b1;
            end
            waited++;
        end
        readout_trigger = 1'b0;
        if (rd_index < IMAGE_SIZE)
            note_failure($sformatf("readout delivered only %0d of %0d words",
                                   rd_index, IMAGE_SIZE));
        // Anything still queued would be a duplicate
        repeat (8) @(negedge clk);
        compare_bit("readout_ready", readout_ready, 1'b0);
        rd_check = 1'b0;
    endtask

    // ========================================
    // Monitors
    // ========================================
    always @(negedge clk) begin
        if (status_capture_done)
            capture_done_seen = 1'b1;
    end

    // A word leaves when ready and trigger are both high at the next edge
    always @(negedge clk) begin
        if (rd_check && readout_ready && readout_trigger) begin
            if (rd_index < IMAGE_SIZE)
                compare_word("readout_data", readout_data, expected_word(cur_seed, rd_index));
            else
                note_failure("readout port delivered a word beyond the image");
            rd_index++;
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failures found");
        $finish;
    end

    // ========================================
    // Test sequence
    // ========================================
    initial begin : main
        logic [31:0] seed_a;
        logic [31:0] seed_b;
        logic [31:0] seed_c;
        logic [31:0] seed_d;
        logic [31:0] seed_e;
        logic [31:0] r;
        int          i;
        int          assert_total;

        fifoIn_rst        = 1'b0;
        cmd               = PIX_CMD_NONE;
        cmd_block         = '0;
        pix_d             = '0;
        pix_fv            = 1'b0;
        pix_lv            = 1'b0;
        readout_trigger   = 1'b0;
        ack_delay         = 4'd0;
        rd_check          = 1'b0;
        rd_index          = 0;
        cur_seed          = '0;
        capture_done_seen = 1'b0;
        error_count       = 0;
        check_count       = 0;
        tests_run         = 0;
        tests_clean       = 0;

        next_random(seed_a);
        next_random(seed_b);
        next_random(seed_c);
        next_random(seed_d);
        next_random(seed_e);

        repeat (10) @(posedge clk);
        #2;
        fifoIn_rst = 1'b1;

        begin_test("reset state");
        repeat (2) @(negedge clk);
        compare_bit("status_capture_done", status_capture_done, 1'b0);
        compare_bit("status_capture_pixel_dropped", status_capture_pixel_dropped, 1'b0);
        compare_bit("status_readout_started", status_readout_started, 1'b0);
        compare_bit("readout_ready", readout_ready, 1'b0);
        compare_bit("wb_cyc", wb_cyc, 1'b0);
        end_test();

        // Arm mid-frame, the partial frame must be skipped
        begin_test("frame sync and storage");
        next_drive_slot();
        pix_fv = 1'b1;
        pix_lv = 1'b1;
        for (i = 0; i < 6; i++) begin
            next_random(r);
            pix_d = r[11:0];
            next_drive_slot();
        end
        issue_capture(2'd1);
        for (i = 0; i < 6; i++) begin
            next_random(r);
            pix_d = r[11:0];
            next_drive_slot();
        end
        // Three bus cycles per write, so 16 blanking cycles let a line drain
        send_frame(seed_a, 16);
        wait_capture_done();
        read_block(2'd1, seed_a, 1'b0);
        end_test();

        begin_test("block independence");
        capture_frame(2'd0, seed_b, 17);
        capture_frame(2'd2, seed_c, 19);
        read_block(2'd2, seed_c, 1'b0);
        read_block(2'd0, seed_b, 1'b0);
        end_test();

        begin_test("readout back-pressure");
        read_block(2'd2, seed_c, 1'b1);
        end_test();

        // Slow memory overflows the input queue on a dense frame
        begin_test("dropped pixels");
        next_drive_slot();
        ack_delay = 4'd6;
        capture_frame(2'd3, seed_d, 0);
        compare_bit("status_capture_pixel_dropped", status_capture_pixel_dropped, 1'b1);
        next_drive_slot();
        ack_delay = 4'd0;
        capture_frame(2'd3, seed_e, 16);
        compare_bit("status_capture_pixel_dropped", status_capture_pixel_dropped, 1'b0);
        read_block(2'd3, seed_e, 1'b0);
        end_test();

        assert_total = dut_i.pix_assertions_i.assert_errors;
        if (assert_total != 0)
            $display("Bound assertions fired %0d times", assert_total);
        $display("Summary: %0d tests, %0d clean, %0d checks, %0d errors",
                 tests_run, tests_clean, check_count, error_count + assert_total);
        if (error_count == 0 && assert_total == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+source
source/pix_pkg.sv
source/pix_fifo.sv
source/pix_input.sv
source/ram_controller.sv
source/pix_controller.sv
dv/wb_ram_model.sv
dv/pix_assertions.sv
dv/pix_tb.sv
